//--- Bender.yml
package:
  name: uart_debug_loader

sources:
  - design/uart_cfg_pkg.sv
  - design/dbg_proto_pkg.sv
  - design/uart_rx_deser.sv
  - design/rx_byte_fifo.sv
  - design/dbg_cmd_engine.sv
  - design/uart_debug_loader.sv
  - target: test
    files:
      - tb/tb_uart_debug_loader.sv

//--- design/dbg_cmd_engine.sv
/*
 * Debug command engine
 * Decodes WRITE and EXEC commands into byte writes and a launch pulse
 */
`timescale 1ns/1ns

module dbg_cmd_engine (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  uart_cfg_pkg::rx_byte_t byte_i,
  input  logic                   empty_i,
  output logic                   pop_o,
  input  logic                   mem_stall_i,
  output logic                   mem_we_o,
  output dbg_proto_pkg::mem_wr_t mem_wr_o,
  output logic                   exec_o,
  output dbg_proto_pkg::addr_t   exec_addr_o,
  output logic                   err_o
);

  import dbg_proto_pkg::*;

  localparam int unsigned CntW = $clog2(FieldBytes);

  typedef enum logic [2:0] {EngIdle, EngAddr, EngLen, EngData, EngEntry} eng_state_e;

  eng_state_e      state_q;
  logic [CntW-1:0] cnt_q;
  addr_t           addr_q;
  addr_t           len_q;
  addr_t           addr_next;
  addr_t           len_next;
  mem_wr_t         wr_q;
  logic            we_pend_q;
  logic            field_last;
  logic            take;

  // One byte per cycle and none while memory stalls
  assign pop_o      = ~empty_i & ~mem_stall_i;
  assign take       = pop_o & ~byte_i.parity_err;
  assign field_last = cnt_q == CntW'(FieldBytes - 1);

  // Little-endian fields shift in from the top
  assign addr_next = {byte_i.data, addr_q[$bits(addr_t)-1:8]};
  assign len_next  = {byte_i.data, len_q[$bits(addr_t)-1:8]};

  assign mem_we_o    = we_pend_q & ~mem_stall_i;
  assign mem_wr_o    = wr_q;
  assign exec_addr_o = addr_q;

  //////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= EngIdle;
      cnt_q     <= '0;
      we_pend_q <= 1'b0;
      exec_o    <= 1'b0;
      err_o     <= 1'b0;
    end else begin
      exec_o <= 1'b0;
      err_o  <= 1'b0;
      if (mem_we_o) we_pend_q <= 1'b0;
      if (pop_o && byte_i.parity_err) begin
        // Corrupted byte kills the command in flight
        state_q <= EngIdle;
        cnt_q   <= '0;
        err_o   <= 1'b1;
      end else if (pop_o) begin
        cnt_q <= field_last ? '0 : cnt_q + 1'b1;
        case (state_q)
          EngIdle: begin
            cnt_q <= '0;
            case (cmd_e'(byte_i.data))
              CmdWrite: state_q <= EngAddr;
              CmdExec:  state_q <= EngEntry;
              // No reply channel for reads
              CmdRead:  err_o <= 1'b1;
              default:  err_o <= 1'b1;
            endcase
          end
          EngAddr: if (field_last) state_q <= EngLen;
          EngLen: if (field_last) begin
            // Zero length writes nothing
            state_q <= (len_next == '0) ? EngIdle : EngData;
          end
          EngData: begin
            we_pend_q <= 1'b1;
            if (len_q == addr_t'(1)) state_q <= EngIdle;
          end
          EngEntry: if (field_last) begin
            state_q <= EngIdle;
            exec_o  <= 1'b1;
          end
          default: state_q <= EngIdle;
        endcase
      end
    end
  end

  // Address, remaining length and write payload
  always_ff @(posedge clk) begin
    if (take) begin
      case (state_q)
        EngAddr, EngEntry: addr_q <= addr_next;
        EngLen: len_q <= len_next;
        EngData: begin
          wr_q.addr <= addr_q;
          wr_q.data <= byte_i.data;
          addr_q    <= addr_q + 1'b1;
          len_q     <= len_q - 1'b1;
        end
        default: ;
      endcase
    end
  end

  // A stalled write is neither dropped nor overwritten
  a_no_we_in_stall: assert property (
    @(posedge clk) disable iff (!arst_n_i)
      we_pend_q && mem_stall_i |=> we_pend_q && $stable(wr_q)
  );

endmodule

//--- design/dbg_proto_pkg.sv
/*
 * Debug protocol package
 * Command codes, field sizes and the memory write port record
 */
package dbg_proto_pkg;

  //////////////////////////////////////////////////
  // Command codes
  //////////////////////////////////////////////////

  // READ is known but needs a transmit path, so it is refused
  typedef enum logic [7:0] {
    CmdRead  = 8'h11,
    CmdWrite = 8'h12,
    CmdExec  = 8'h13
  } cmd_e;

  //////////////////////////////////////////////////
  // Fields and memory port
  //////////////////////////////////////////////////

  // Address and length fields, little-endian on the wire
  localparam int unsigned FieldBytes = 8;

  typedef logic [8*FieldBytes-1:0] addr_t;

  // One byte write
  typedef struct packed {
    addr_t      addr;
    logic [7:0] data;
  } mem_wr_t;

endpackage

//--- design/rx_byte_fifo.sv
/*
 * Receive byte FIFO
 * Circular buffer between the UART receiver and the command engine
 */
`timescale 1ns/1ns

module rx_byte_fifo #(
  parameter int unsigned FifoDepth = 8
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   push_i,
  input  uart_cfg_pkg::rx_byte_t data_i,
  input  logic                   pop_i,
  output uart_cfg_pkg::rx_byte_t data_o,
  output logic                   empty_o,
  output logic                   overflow_o
);

  import uart_cfg_pkg::*;

  localparam int unsigned PtrW = $clog2(FifoDepth);

  rx_byte_t        mem_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            full;
  logic            do_push;
  logic            do_pop;

  assign full    = count_q == (PtrW+1)'(FifoDepth);
  assign empty_o = count_q == '0;
  // Bytes arriving while full are lost
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (PtrW+1)'(do_push) - (PtrW+1)'(do_pop);
      if (push_i && full) overflow_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n_i) pop_i |-> !empty_o
  );

endmodule

//--- design/uart_cfg_pkg.sv
/*
 * UART configuration package
 * Frame constants and the received-byte record used along the receive path
 */
package uart_cfg_pkg;

  //////////////////////////////////////////////////
  // Frame format
  //////////////////////////////////////////////////

  // Data bits per frame, sent LSB first
  localparam int unsigned DataBits = 8;

  // Line levels
  localparam logic IdleLevel  = 1'b1;
  localparam logic StartLevel = 1'b0;
  localparam logic StopLevel  = 1'b1;

  //////////////////////////////////////////////////
  // Received byte
  //////////////////////////////////////////////////

  // Parity error also flags a broken stop bit
  typedef struct packed {
    logic [DataBits-1:0] data;
    logic                parity_err;
  } rx_byte_t;

endpackage

//--- design/uart_debug_loader.sv
/*
 * UART debug loader top level
 * Receiver, byte FIFO and command engine in a chain
 */
`timescale 1ns/1ns

module uart_debug_loader #(
  parameter int unsigned ClkPerBaud = 16,
  parameter int unsigned ParityEna  = 0,
  parameter int unsigned FifoDepth  = 8
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   rx_i,
  input  logic                   mem_stall_i,
  output logic                   mem_we_o,
  output dbg_proto_pkg::mem_wr_t mem_wr_o,
  output logic                   exec_o,
  output dbg_proto_pkg::addr_t   exec_addr_o,
  output logic                   err_o,
  output logic                   overflow_o
);

  import uart_cfg_pkg::*;

  rx_byte_t rx_byte;
  rx_byte_t fifo_byte;
  logic     byte_valid;
  logic     fifo_empty;
  logic     fifo_pop;

  // Serial line to bytes
  uart_rx_deser #(
    .ClkPerBaud ( ClkPerBaud ),
    .ParityEna  ( ParityEna  )
  ) rx_deser_i (
    .clk          ( clk        ),
    .arst_n_i     ( arst_n_i   ),
    .rx_i         ( rx_i       ),
    .byte_valid_o ( byte_valid ),
    .byte_o       ( rx_byte    )
  );

  rx_byte_fifo #(
    .FifoDepth ( FifoDepth )
  ) byte_fifo_i (
    .clk        ( clk        ),
    .arst_n_i   ( arst_n_i   ),
    .push_i     ( byte_valid ),
    .data_i     ( rx_byte    ),
    .pop_i      ( fifo_pop   ),
    .data_o     ( fifo_byte  ),
    .empty_o    ( fifo_empty ),
    .overflow_o ( overflow_o )
  );

  // Bytes to memory writes and launch
  dbg_cmd_engine cmd_engine_i (
    .clk         ( clk         ),
    .arst_n_i    ( arst_n_i    ),
    .byte_i      ( fifo_byte   ),
    .empty_i     ( fifo_empty  ),
    .pop_o       ( fifo_pop    ),
    .mem_stall_i ( mem_stall_i ),
    .mem_we_o    ( mem_we_o    ),
    .mem_wr_o    ( mem_wr_o    ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o ),
    .err_o       ( err_o       )
  );

endmodule

//--- design/uart_rx_deser.sv
/*
 * UART receiver
 * Samples the serial line at mid-bit and emits bytes with a parity flag
 */
`timescale 1ns/1ns

module uart_rx_deser #(
  parameter int unsigned ClkPerBaud = 16,
  parameter int unsigned ParityEna  = 0
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   rx_i,
  output logic                   byte_valid_o,
  output uart_cfg_pkg::rx_byte_t byte_o
);

  import uart_cfg_pkg::*;

  localparam int unsigned BaudW = $clog2(ClkPerBaud);
  localparam int unsigned BitW  = $clog2(DataBits);

  typedef enum logic [2:0] {RxIdle, RxStart, RxData, RxParity, RxStop} rx_state_e;

  rx_state_e           state_q;
  logic [1:0]          sync_q;
  logic                rx_prev_q;
  logic [BaudW-1:0]    baud_cnt_q;
  logic [BitW-1:0]     bit_cnt_q;
  logic [DataBits-1:0] shift_q;
  logic                par_err_q;
  logic                rx_s;
  logic                start_edge;
  logic                start_mid;
  logic                bit_mid;

  assign rx_s       = sync_q[1];
  assign start_edge = (rx_prev_q == IdleLevel) && (rx_s == StartLevel);
  // Start bit is checked half a bit in and the rest one full bit apart
  assign start_mid  = baud_cnt_q == BaudW'(ClkPerBaud/2 - 1);
  assign bit_mid    = baud_cnt_q == BaudW'(ClkPerBaud - 1);

  // Two-flop synchronizer plus edge history
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q    <= {2{IdleLevel}};
      rx_prev_q <= IdleLevel;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_s;
    end
  end

  //////////////////////////////////////////////////
  // Frame sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= RxIdle;
      baud_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      baud_cnt_q   <= baud_cnt_q + 1'b1;
      case (state_q)
        RxIdle: begin
          baud_cnt_q <= '0;
          if (start_edge) state_q <= RxStart;
        end
        RxStart: if (start_mid) begin
          baud_cnt_q <= '0;
          bit_cnt_q  <= '0;
          // High at mid start bit means a glitch
          state_q    <= (rx_s == StartLevel) ? RxData : RxIdle;
        end
        RxData: if (bit_mid) begin
          baud_cnt_q <= '0;
          bit_cnt_q  <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == BitW'(DataBits - 1)) begin
            state_q <= (ParityEna != 0) ? RxParity : RxStop;
          end
        end
        RxParity: if (bit_mid) begin
          baud_cnt_q <= '0;
          state_q    <= RxStop;
        end
        RxStop: if (bit_mid) begin
          baud_cnt_q   <= '0;
          byte_valid_o <= 1'b1;
          state_q      <= RxIdle;
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  // Data path, shifted in LSB first
  always_ff @(posedge clk) begin
    if (state_q == RxStart && start_mid) par_err_q <= 1'b0;
    if (state_q == RxData && bit_mid) shift_q <= {rx_s, shift_q[DataBits-1:1]};
    // Even parity over data and parity bit
    if (state_q == RxParity && bit_mid) par_err_q <= rx_s ^ (^shift_q);
    if (state_q == RxStop && bit_mid) begin
      byte_o.data       <= shift_q;
      byte_o.parity_err <= par_err_q | (rx_s != StopLevel);
    end
  end

  // Next byte needs at least the data and stop bits of a new frame
  a_single_valid: assert property (
    @(posedge clk) disable iff (!arst_n_i)
      byte_valid_o |=> !byte_valid_o [*(DataBits + 1) * ClkPerBaud]
  );

endmodule

//--- src.f
design/uart_cfg_pkg.sv
design/dbg_proto_pkg.sv
design/uart_rx_deser.sv
design/rx_byte_fifo.sv
design/dbg_cmd_engine.sv
design/uart_debug_loader.sv
tb/tb_uart_debug_loader.sv

//--- tb/tb_uart_debug_loader.sv
/*
 * Testbench for the UART debug loader
 * Random serial commands checked against a queue model, with stall and watchdog
 */
`timescale 1ns/1ns

module tb_uart_debug_loader;

  import uart_cfg_pkg::*;
  import dbg_proto_pkg::*;

  localparam int ClkPerBaud     = 16;
  localparam int ClkPeriod      = 4;
  localparam int ResetCycles    = 16;
  localparam int NumWrites      = 8;
  localparam int NumExecs       = 3;
  localparam int NumStallWrites = 6;
  // Start, data, parity and stop bits plus the largest idle gap
  localparam int FrameBits      = DataBits + 3;
  localparam int FrameCycles    = FrameBits * ClkPerBaud + 4;
  localparam int DrainCycles    = 2 * FrameCycles;
  localparam int MaxFrames      = (NumWrites + NumStallWrites + 3) * (1 + 2 * FieldBytes + 8)
                                + (NumExecs + 3) * (1 + FieldBytes) + 3;
  localparam longint WatchdogNs = longint'(MaxFrames * FrameCycles + ResetCycles) * 3 / 2
                                * ClkPeriod;

  logic    clk;
  logic    arst_n_i;
  logic    rx_i;
  logic    mem_stall_i;
  logic    mem_we_o;
  mem_wr_t mem_wr_o;
  logic    exec_o;
  addr_t   exec_addr_o;
  logic    err_o;
  logic    overflow_o;

  // Reference model
  mem_wr_t exp_wr[$];
  addr_t   exp_exec[$];
  mem_wr_t exp_w;
  addr_t   exp_a;
  int      exp_err;
  int      err_seen;
  int      writes_seen;
  int      execs_seen;
  int      errors;
  bit      ovf_reported;
  bit      stall_run;
  integer  seed;
  integer  stall_seed;

  uart_debug_loader #(
    .ClkPerBaud ( ClkPerBaud ),
    .ParityEna  ( 1          ),
    .FifoDepth  ( 8          )
  ) dut_i (
    .clk         ( clk         ),
    .arst_n_i    ( arst_n_i    ),
    .rx_i        ( rx_i        ),
    .mem_stall_i ( mem_stall_i ),
    .mem_we_o    ( mem_we_o    ),
    .mem_wr_o    ( mem_wr_o    ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o ),
    .err_o       ( err_o       ),
    .overflow_o  ( overflow_o  )
  );

  initial clk = 1'b0;
  always #(ClkPeriod/2) clk = ~clk;

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_write(input mem_wr_t exp, input mem_wr_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %0t: write got addr %h data %h, expected addr %h data %h",
               $time, act.addr, act.data, exp.addr, exp.data);
    end
  endtask

  task automatic check_exec(input addr_t exp, input addr_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %0t: launch address %h, expected %h", $time, act, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %0t: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Serial stimulus
  //////////////////////////////////////////////////

  task automatic drive_bit(input logic b);
    rx_i = b;
    repeat (ClkPerBaud) @(posedge clk);
    #1;
  endtask

  // One frame with even parity that can be flipped on request
  task automatic send_byte(input logic [7:0] b, input bit bad_par);
    int i;
    int gap;
    drive_bit(1'b0);
    for (i = 0; i < DataBits; i++) drive_bit(b[i]);
    drive_bit((^b) ^ bad_par);
    drive_bit(1'b1);
    gap = {$random(seed)} % 4;
    repeat (gap) @(posedge clk);
    #1;
  endtask

  // Little-endian field with the last byte optionally corrupted
  task automatic send_field(input addr_t v, input bit bad_last);
    int i;
    for (i = 0; i < FieldBytes; i++) begin
      send_byte(v[8*i +: 8], bad_last && (i == FieldBytes - 1));
    end
  endtask

  function automatic addr_t rand_addr();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic send_write(input addr_t addr, input int len);
    mem_wr_t w;
    logic [7:0] data;
    int i;
    send_byte(CmdWrite, 1'b0);
    send_field(addr, 1'b0);
    send_field(addr_t'(len), 1'b0);
    for (i = 0; i < len; i++) begin
      data   = $random(seed);
      w.addr = addr + addr_t'(i);
      w.data = data;
      exp_wr.push_back(w);
      send_byte(data, 1'b0);
    end
  endtask

  task automatic send_exec(input addr_t entry, input bit bad_last);
    send_byte(CmdExec, 1'b0);
    if (bad_last) exp_err++;
    else exp_exec.push_back(entry);
    send_field(entry, bad_last);
  endtask

  // Waits until the model has seen every expected result
  task automatic wait_done();
    int cycles;
    cycles = 0;
    while ((exp_wr.size() != 0 || exp_exec.size() != 0 || err_seen != exp_err)
           && cycles < DrainCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_wr.size() != 0 || exp_exec.size() != 0 || err_seen != exp_err) begin
      errors++;
      $display("Missing result: %0d writes and %0d launches still outstanding,",
               exp_wr.size(), exp_exec.size());
      $display("  %0d of %0d error pulses seen", err_seen, exp_err);
      exp_wr.delete();
      exp_exec.delete();
      err_seen = exp_err;
    end
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (arst_n_i) begin
      if (mem_we_o) begin
        check_flag("mem_stall_i at write strobe", 1'b0, mem_stall_i);
        if (exp_wr.size() == 0) begin
          errors++;
          $display("Unexpected write to address %h when no write was pending", mem_wr_o.addr);
        end else begin
          exp_w = exp_wr.pop_front();
          check_write(exp_w, mem_wr_o);
          writes_seen++;
        end
      end
      if (exec_o) begin
        if (exp_exec.size() == 0) begin
          errors++;
          $display("Unexpected launch at address %h", exec_addr_o);
        end else begin
          exp_a = exp_exec.pop_front();
          check_exec(exp_a, exec_addr_o);
          execs_seen++;
        end
      end
      if (err_o) err_seen++;
      if (overflow_o && !ovf_reported) begin
        ovf_reported = 1'b1;
        errors++;
        $display("The receive FIFO overflowed and dropped a byte");
      end
    end
  end

  // Watchdog
  initial begin
    #(WatchdogNs);
    $display("Timeout: the run did not finish in the expected time");
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int n;
    int hi;
    int lo;
    logic [7:0] cmd;
    seed        = 32'h6c4b;
    stall_seed  = 32'h6c4b;
    rx_i        = 1'b1;
    mem_stall_i = 1'b0;
    arst_n_i    = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk);
    check_flag("mem_we_o", 1'b0, mem_we_o);
    check_flag("exec_o", 1'b0, exec_o);
    check_flag("err_o", 1'b0, err_o);
    check_flag("overflow_o", 1'b0, overflow_o);
    @(posedge clk);
    #1;

    for (n = 0; n < NumWrites; n++) begin
      send_write(rand_addr(), 1 + {$random(seed)} % 8);
      wait_done();
    end
    send_write(rand_addr(), 0);
    wait_done();
    for (n = 0; n < NumExecs; n++) begin
      send_exec(rand_addr(), 1'b0);
      wait_done();
    end

    // Refused commands with a valid one after each
    send_byte(CmdRead, 1'b0);
    exp_err++;
    wait_done();
    send_write(rand_addr(), 1 + {$random(seed)} % 8);
    wait_done();
    do cmd = $random(seed); while (cmd == CmdWrite || cmd == CmdExec);
    send_byte(cmd, 1'b0);
    exp_err++;
    wait_done();
    send_exec(rand_addr(), 1'b0);
    wait_done();
    send_byte(CmdWrite, 1'b1);
    exp_err++;
    wait_done();
    send_write(rand_addr(), 1 + {$random(seed)} % 8);
    wait_done();
    send_exec(rand_addr(), 1'b1);
    wait_done();
    send_exec(rand_addr(), 1'b0);
    wait_done();

    // Memory back-pressure in bursts shorter than a frame
    stall_run = 1'b1;
    fork
      begin
        for (n = 0; n < NumStallWrites; n++) begin
          send_write(rand_addr(), 1 + {$random(seed)} % 8);
          wait_done();
        end
        stall_run = 1'b0;
      end
      begin
        while (stall_run) begin
          hi = 1 + {$random(stall_seed)} % (FrameBits * ClkPerBaud - 30);
          lo = 1 + {$random(stall_seed)} % 40;
          mem_stall_i = 1'b1;
          repeat (hi) @(posedge clk);
          #1;
          mem_stall_i = 1'b0;
          repeat (lo) @(posedge clk);
          #1;
        end
      end
    join
    wait_done();

    $display("Writes %0d, launches %0d, error pulses %0d, errors %0d",
             writes_seen, execs_seen, err_seen, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
